// File: dv/exec_stimulus.txt
# op src1 src2 ovf_kind cancel exp_result exp_overflow test_name (operands and results in hex)
add   7fffffff 00000001 add  0 80000000 1 add_ovf_pos
add   7fffffff 00000001 none 0 80000000 0 add_ovf_masked
sub   80000000 00000001 sub  0 7fffffff 1 sub_ovf_neg
sub   80000000 00000001 none 0 7fffffff 0 sub_ovf_masked
sub   00000003 00000005 sub  0 fffffffe 0 sub_no_ovf
slt   ffffffff 00000001 none 0 00000001 0 slt_neg_pos
sltu  ffffffff 00000001 none 0 00000000 0 sltu_big_small
and   f0f0f0f0 ff00ff00 none 0 f000f000 0 and_mask
or    f0f0f0f0 0f0f0000 none 0 fffff0f0 0 or_merge
nor   00000000 00000000 none 0 ffffffff 0 nor_zero
xor   aaaaaaaa ffffffff none 0 55555555 0 xor_invert
sll   0000001f 00000001 none 0 80000000 0 sll_by31
srl   00000000 80000000 none 0 80000000 0 srl_by0
sra   0000001f 80000000 none 0 ffffffff 0 sra_by31
lui   00000000 ffff1234 none 0 12340000 0 lui_low_half
mult  fffffffe 00000003 none 0 00000000 0 mult_neg
mfhi  00000000 00000000 none 0 ffffffff 0 mult_neg_hi
mflo  00000000 00000000 none 0 fffffffa 0 mult_neg_lo
multu ffffffff ffffffff none 0 00000000 0 multu_max
mfhi  00000000 00000000 none 0 fffffffe 0 multu_max_hi
mflo  00000000 00000000 none 0 00000001 0 multu_max_lo
div   fffffff9 00000002 none 0 00000000 0 div_mixed
mfhi  00000000 00000000 none 0 ffffffff 0 div_mixed_rem
mflo  00000000 00000000 none 0 fffffffd 0 div_mixed_quo
divu  fffffff9 00000002 none 0 00000000 0 divu_big
mfhi  00000000 00000000 none 0 00000001 0 divu_big_rem
mflo  00000000 00000000 none 0 7ffffffc 0 divu_big_quo
div   fffffff9 00000000 none 0 00000000 0 div_by_zero
mfhi  00000000 00000000 none 0 fffffff9 0 div_zero_rem
mflo  00000000 00000000 none 0 ffffffff 0 div_zero_quo
mthi  12345678 00000000 none 0 00000000 0 mthi_set
mtlo  9abcdef0 00000000 none 0 00000000 0 mtlo_set
mfhi  00000000 00000000 none 0 12345678 0 mthi_read
mflo  00000000 00000000 none 0 9abcdef0 0 mtlo_read
mult  00000002 00000003 none 1 00000000 0 mult_cancel
div   00000064 00000007 none 1 00000000 0 div_cancel
mthi  deadbeef 00000000 none 1 00000000 0 mthi_cancel
mfhi  00000000 00000000 none 0 12345678 0 cancel_keep_hi
mflo  00000000 00000000 none 0 9abcdef0 0 cancel_keep_lo

// File: dv/exec_unit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit_checker
    import ex_op_pkg::*;
    import ex_bus_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   req_valid,
    input  wire                   req_ready,
    input  wire                   resp_valid,
    input  wire                   resp_ready,
    input  wire ex_resp_t         resp,
    input  wire  [data_width-1:0] exp_result,
    input  wire                   exp_overflow,
    input  wire  [8*24-1:0]       exp_name,
    output int                    mismatches,
    output int                    unexpected,
    output int                    pending
);

    typedef struct packed {
        logic [8*24-1:0]       name;
        logic [data_width-1:0] result;
        logic                  overflow;
    } exp_entry_t;

    exp_entry_t exp_q[$];   // oldest request first
    exp_entry_t head;

    initial begin
        mismatches = 0;
        unexpected = 0;
        pending    = 0;
    end

    always @(posedge clk) begin
        if (!reset) begin
            // a request is never answered in its own transfer cycle
            if (resp_valid && resp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("response %h arrived with no request left to answer",
                             resp.result);
                    unexpected++;
                end else begin
                    head = exp_q.pop_front();
                    if (resp.result !== head.result || resp.overflow !== head.overflow) begin
                        $display("error: %0s expected %h/%0b, actual %h/%0b", head.name,
                                 head.result, head.overflow, resp.result, resp.overflow);
                        mismatches++;
                    end
                end
            end
            if (req_valid && req_ready)
                exp_q.push_back({exp_name, exp_result, exp_overflow});
            pending = exp_q.size();
        end
    end

    task automatic report_leftovers();
        if (exp_q.size() != 0)
            $display("%0d expected responses never arrived", exp_q.size());
    endtask

endmodule

`default_nettype wire

// File: dv/exec_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit_tb
    import ex_op_pkg::*;
    import ex_bus_pkg::*;
();

    typedef struct packed {
        ex_req_t               req;
        logic [data_width-1:0] result;
        logic                  overflow;
        logic [8*24-1:0]       name;
    } vector_t;

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    logic                  req_ready;
    ex_req_t               req;
    logic                  resp_valid;
    logic                  resp_ready = 1'b0;
    ex_resp_t              resp;
    logic [data_width-1:0] exp_result;
    logic                  exp_overflow;
    logic [8*24-1:0]       exp_name;
    int                    mismatches;
    int                    unexpected;
    int                    pending;
    int                    bad_lines   = 0;
    integer                seed        = 24;
    int                    cycle_count = 0;
    int                    cycle_limit = 0;  // zero until the vectors are loaded
    vector_t               vectors[$];

    exec_unit uut (.*);

    exec_unit_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // random back-pressure on the response stream
    always @(negedge clk) begin
        if (reset)
            resp_ready = 1'b0;
        else
            resp_ready = ($random(seed) & 3) != 0;  // stall about one cycle in four
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            u_checker.report_leftovers();
            $display("run hung, no finish after %0d cycles", cycle_count);
            print_counts();
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic print_counts();
        $display("mismatches %0d, unexpected %0d, missing %0d, bad stimulus lines %0d",
                 mismatches, unexpected, pending, bad_lines);
    endtask

    task automatic load_vectors();
        int                    fd;
        int                    n;
        int                    cancel;
        int                    overflow;
        string                 op_name;
        string                 ovf_name;
        logic [8*100-1:0]      legend;
        logic [data_width-1:0] src1;
        logic [data_width-1:0] src2;
        logic [data_width-1:0] result;
        logic [8*24-1:0]       name;
        ex_op_e                op;
        vector_t               v;

        fd = $fopen("dv/exec_stimulus.txt", "r");
        if (fd == 0) begin
            $display("stimulus file dv/exec_stimulus.txt could not be opened");
            bad_lines++;
            return;
        end
        n = $fgets(legend, fd);  // column legend
        if (n == 0) begin
            $display("stimulus file dv/exec_stimulus.txt is empty");
            bad_lines++;
        end
        while ($fscanf(fd, "%s %h %h %s %d %h %d %s\n", op_name, src1, src2, ovf_name,
                       cancel, result, overflow, name) == 8) begin
            // mnemonic lookup among the operation codes
            op = op.first();
            while (op.name() != {"op_", op_name} && op != op.last())
                op = op.next();
            if (op.name() != {"op_", op_name}) begin
                $display("stimulus line %0s names an unknown operation %s", name, op_name);
                bad_lines++;
            end
            v.req.op       = op;
            v.req.src1     = src1;
            v.req.src2     = src2;
            v.req.ovf_kind = (ovf_name == "add") ? ovf_add
                           : (ovf_name == "sub") ? ovf_sub : ovf_none;
            v.req.cancel   = cancel[0];
            v.result       = result;
            v.overflow     = overflow[0];
            v.name         = name;
            vectors.push_back(v);
        end
        $fclose(fd);
    endtask

    initial begin
        vector_t v;

        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        exp_result   = '0;
        exp_overflow = 1'b0;
        exp_name     = '0;
        load_vectors();
        cycle_limit = vectors.size() * 80 + 200;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < vectors.size(); i++) begin
            v            = vectors[i];
            req_valid    = 1'b1;
            req          = v.req;
            exp_result   = v.result;
            exp_overflow = v.overflow;
            exp_name     = v.name;
            // ready only follows the input register fill and is stable here
            while (!req_ready)
                @(negedge clk);
            @(negedge clk);  // transfer took place on the edge before
        end
        req_valid = 1'b0;
        while (pending > 0)
            @(negedge clk);
        repeat (10)
            @(negedge clk);  // room for a stray extra response
        print_counts();
        if (bad_lines == 0 && mismatches == 0 && unexpected == 0 && vectors.size() > 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
verilog/ex_op_pkg.sv
verilog/ex_bus_pkg.sv
verilog/stream_reg.sv
verilog/alu_core.sv
verilog/serial_divider.sv
verilog/muldiv_unit.sv
verilog/exec_unit.sv
dv/exec_unit_checker.sv
dv/exec_unit_tb.sv

// File: verilog/alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module alu_core
    import ex_op_pkg::*;
(
    input  wire ex_op_e           op,
    input  wire ovf_kind_e        ovf_kind,
    input  wire  [data_width-1:0] src1,
    input  wire  [data_width-1:0] src2,
    input  wire  [data_width-1:0] hi,
    input  wire  [data_width-1:0] lo,
    output logic [data_width-1:0] result,
    output logic                  overflow
);

    localparam int msb     = data_width - 1;
    localparam int sh_bits = $clog2(data_width);

    logic                    sub_like;
    logic [data_width-1:0]   adder_b;
    logic [data_width-1:0]   sum;
    logic                    carry;
    logic                    slt_bit;
    logic                    sra_fill;
    logic [data_width-1:0]   sll_res;
    logic [2*data_width-1:0] sr_wide;

    // sub, slt and sltu share the adder as a + ~b + 1
    assign sub_like = (op == op_sub) || (op == op_slt) || (op == op_sltu);
    assign adder_b  = sub_like ? ~src2 : src2;

    assign {carry, sum} = {1'b0, src1} + {1'b0, adder_b}
                        + {{data_width{1'b0}}, sub_like};

    // signs differ: negative one is less, else the difference sign decides
    assign slt_bit = (src1[msb] & ~src2[msb])
                   | (~(src1[msb] ^ src2[msb]) & sum[msb]);

    assign sll_res  = src2 << src1[sh_bits-1:0];
    assign sra_fill = (op == op_sra) & src2[msb];
    assign sr_wide  = {{data_width{sra_fill}}, src2} >> src1[sh_bits-1:0];

    // same-sign addends with a sum of the other sign
    always_comb begin
        case (ovf_kind)
            ovf_add:
                overflow = (src1[msb] == src2[msb]) && (sum[msb] != src1[msb]);
            ovf_sub:
                overflow = (src1[msb] != src2[msb]) && (sum[msb] != src1[msb]);
            default:
                overflow = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            op_add,
            op_sub:  result = sum;
            op_slt:  result = {{(data_width-1){1'b0}}, slt_bit};
            op_sltu: result = {{(data_width-1){1'b0}}, ~carry};  // borrow out
            op_and:  result = src1 & src2;
            op_or:   result = src1 | src2;
            op_nor:  result = ~(src1 | src2);
            op_xor:  result = src1 ^ src2;
            op_sll:  result = sll_res;
            op_srl,
            op_sra:  result = sr_wide[data_width-1:0];
            op_lui:  result = {src2[15:0], 16'b0};
            op_mfhi: result = hi;
            op_mflo: result = lo;
            default: result = '0;  // mult, div and moves to hi/lo
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/ex_bus_pkg.sv
`default_nettype none

package ex_bus_pkg;

    import ex_op_pkg::*;

    // request stream payload, 72 bits
    typedef struct packed {
        ex_op_e                op;
        logic [data_width-1:0] src1;
        logic [data_width-1:0] src2;
        ovf_kind_e             ovf_kind;
        logic                  cancel;    // instruction killed by an exception
    } ex_req_t;

    // response stream payload, 33 bits
    typedef struct packed {
        logic [data_width-1:0] result;
        logic                  overflow;
    } ex_resp_t;

endpackage

`default_nettype wire

// File: verilog/ex_op_pkg.sv
`default_nettype none

package ex_op_pkg;

    localparam int data_width = 32;  // source and result width
    localparam int div_steps  = 32;  // one quotient bit per step

    // operation code carried by every request
    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_nor,
        op_xor,
        op_sll,
        op_srl,
        op_sra,
        op_lui,
        op_mult,
        op_multu,
        op_div,
        op_divu,
        op_mfhi,
        op_mflo,
        op_mthi,
        op_mtlo
    } ex_op_e;

    // which signed overflow rule applies to the adder result
    typedef enum logic [1:0] {
        ovf_none,
        ovf_add,
        ovf_sub
    } ovf_kind_e;

endpackage

`default_nettype wire

// File: verilog/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit
    import ex_op_pkg::*;
    import ex_bus_pkg::*;
(
    input  wire          clk,
    input  wire          reset,
    input  wire          req_valid,
    output logic         req_ready,
    input  wire ex_req_t req,
    output logic         resp_valid,
    input  wire          resp_ready,
    output ex_resp_t     resp
);

    ex_req_t               head;
    logic                  head_valid;
    logic                  out_room;
    logic                  is_div;
    logic                  div_pending;   // divide issued and waiting for op_done
    logic                  issue;
    logic                  op_done;
    logic [data_width-1:0] alu_result;
    logic                  alu_overflow;
    logic [data_width-1:0] hi;
    logic [data_width-1:0] lo;
    ex_resp_t              resp_d;

    // head leaves the input register when its response is pushed
    stream_reg #(.payload_t(ex_req_t)) u_req_reg (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (head_valid),
        .out_ready (op_done),
        .out_data  (head)
    );

    assign is_div = (head.op == op_div) || (head.op == op_divu);

    // output room cannot shrink during a divide since nothing else pushes
    assign issue = head_valid && out_room && !div_pending;

    always_ff @(posedge clk) begin
        if (reset)
            div_pending <= 1'b0;
        else if (issue && is_div)
            div_pending <= 1'b1;
        else if (op_done)
            div_pending <= 1'b0;
    end

    alu_core u_alu (
        .op       (head.op),
        .ovf_kind (head.ovf_kind),
        .src1     (head.src1),
        .src2     (head.src2),
        .hi       (hi),
        .lo       (lo),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    muldiv_unit u_muldiv (
        .clk     (clk),
        .reset   (reset),
        .op      (head.op),
        .src1    (head.src1),
        .src2    (head.src2),
        .cancel  (head.cancel),
        .issue   (issue),
        .op_done (op_done),
        .hi      (hi),
        .lo      (lo)
    );

    always_comb begin
        resp_d.result   = alu_result;  // alu gives zero for div and divu
        resp_d.overflow = alu_overflow && !is_div;
    end

    stream_reg #(.payload_t(ex_resp_t)) u_resp_reg (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (op_done),
        .in_ready  (out_room),
        .in_data   (resp_d),
        .out_valid (resp_valid),
        .out_ready (resp_ready),
        .out_data  (resp)
    );

endmodule

`default_nettype wire

// File: verilog/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit
    import ex_op_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire ex_op_e           op,
    input  wire  [data_width-1:0] src1,
    input  wire  [data_width-1:0] src2,
    input  wire                   cancel,
    input  wire                   issue,
    output logic                  op_done,
    output logic [data_width-1:0] hi,
    output logic [data_width-1:0] lo
);

    logic                           is_div;
    logic                           is_signed_div;
    logic                           div_start;
    logic                           div_busy;
    logic                           div_done;
    logic [data_width-1:0]          div_quo;
    logic [data_width-1:0]          div_rem;
    logic                           div_cancel_q;
    logic signed [2*data_width-1:0] prod_s;
    logic [2*data_width-1:0]        prod_u;
    logic                           wr_en;

    assign is_div        = (op == op_div) || (op == op_divu);
    assign is_signed_div = (op == op_div);
    assign div_start     = issue && is_div && !div_busy;

    assign prod_s = $signed(src1) * $signed(src2);
    assign prod_u = {{data_width{1'b0}}, src1} * {{data_width{1'b0}}, src2};

    assign wr_en = issue && !cancel;  // killed instructions leave hi/lo alone

    // everything but a divide finishes in its issue cycle
    assign op_done = (issue && !is_div) || div_done;

    serial_divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (is_signed_div),
        .dividend  (src1),
        .divisor   (src2),
        .busy      (div_busy),
        .done      (div_done),
        .quotient  (div_quo),
        .remainder (div_rem)
    );

    // cancel of the running divide, applied when it completes
    always_ff @(posedge clk) begin
        if (div_start)
            div_cancel_q <= cancel;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (div_done) begin
            if (!div_cancel_q) begin
                hi <= div_rem;
                lo <= div_quo;
            end
        end else if (wr_en) begin
            case (op)
                op_mult:  {hi, lo} <= prod_s;
                op_multu: {hi, lo} <= prod_u;
                op_mthi:  hi <= src1;
                op_mtlo:  lo <= src1;
                default:  ;  // no hi/lo side effect
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/serial_divider.sv
`timescale 1ns/1ps
`default_nettype none

module serial_divider
    import ex_op_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   start,
    input  wire                   is_signed,
    input  wire  [data_width-1:0] dividend,
    input  wire  [data_width-1:0] divisor,
    output logic                  busy,
    output logic                  done,
    output logic [data_width-1:0] quotient,
    output logic [data_width-1:0] remainder
);

    localparam int msb      = data_width - 1;
    localparam int cnt_bits = $clog2(div_steps);

    logic                  neg_a;
    logic                  neg_b;
    logic [data_width-1:0] abs_a;
    logic [data_width-1:0] abs_b;
    logic [cnt_bits-1:0]   step_cnt;
    logic [data_width-1:0] quo_q;      // dividend bits shift out, quotient bits in
    logic [data_width-1:0] rem_q;
    logic [data_width-1:0] divr_q;
    logic                  neg_quo_q;
    logic                  neg_rem_q;
    logic                  zero_div_q;
    logic [data_width:0]   rem_shift;
    logic [data_width:0]   trial;

    // work on magnitudes, signs are restored at the output
    assign neg_a = is_signed & dividend[msb];
    assign neg_b = is_signed & divisor[msb];
    assign abs_a = neg_a ? -dividend : dividend;
    assign abs_b = neg_b ? -divisor : divisor;

    assign rem_shift = {rem_q, quo_q[msb]};
    assign trial     = rem_shift - {1'b0, divr_q};  // top bit set means it does not fit

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == cnt_bits'(div_steps - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;  // results settle on this edge
                end
            end else if (start) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            quo_q      <= abs_a;
            rem_q      <= '0;
            divr_q     <= abs_b;
            neg_quo_q  <= neg_a ^ neg_b;
            neg_rem_q  <= neg_a;       // remainder follows the dividend
            zero_div_q <= (divisor == '0);
        end else if (busy) begin
            if (!trial[data_width]) begin
                rem_q <= trial[data_width-1:0];
                quo_q <= {quo_q[data_width-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[data_width-1:0];  // restore
                quo_q <= {quo_q[data_width-2:0], 1'b0};
            end
        end
    end

    // x / 0 leaves the dividend as remainder, quotient forced to all ones
    assign quotient  = zero_div_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
    assign remainder = neg_rem_q ? -rem_q : rem_q;

endmodule

`default_nettype wire

// File: verilog/stream_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stream_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  wire      out_ready,
    output payload_t out_data
);

    payload_t   mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;    // entries held, 0 to 2
    logic       push;
    logic       pop;

    // both flags decode the count flop only, never the far side
    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);

    assign push     = in_valid && in_ready;
    assign pop      = out_valid && out_ready;
    assign out_data = mem[rd_ptr];  // oldest entry

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

`default_nettype wire
